/* logic/ff_pkg.sv */
package ff_pkg;

	// Network shape
	localparam int N_INPUT    = 2;
	localparam int N_HIDDEN_1 = 8;
	localparam int N_HIDDEN_2 = 8;
	localparam int N_OUTPUT   = 3;

	// Fixed point format, Q7.8
	localparam int DATA_W     = 16;
	localparam int ACC_W      = 32;
	localparam int FRAC_BITS  = 8;
	localparam int LEAK_SHIFT = 3;              // Leak factor of 1/8

	localparam int NODE_IDX_W    = 6;
	localparam int WEIGHT_ADDR_W = 11;

	// Weight words per layer, bias included
	localparam int W_COUNT_H1  = N_HIDDEN_1 * (N_INPUT + 1);
	localparam int W_COUNT_H2  = N_HIDDEN_2 * (N_HIDDEN_1 + 1);
	localparam int W_COUNT_OUT = N_OUTPUT * (N_HIDDEN_2 + 1);

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [NODE_IDX_W-1:0]    node_idx_t;
	typedef logic [WEIGHT_ADDR_W-1:0] weight_addr_t;

	localparam data_t ONE_FIXED = data_t'(1 << FRAC_BITS);
	localparam data_t DATA_MAX  = data_t'((2 ** (DATA_W - 1)) - 1);
	localparam data_t DATA_MIN  = data_t'(-(2 ** (DATA_W - 1)));

	// LAYER_INPUT doubles as the idle state
	typedef enum logic [1:0] {
		LAYER_INPUT    = 2'd0,
		LAYER_HIDDEN_1 = 2'd1,
		LAYER_HIDDEN_2 = 2'd2,
		LAYER_OUTPUT   = 2'd3
	} layer_e;

	typedef struct packed {
		logic         valid;
		layer_e       layer;
		weight_addr_t addr;
	} weight_req_t;

	typedef struct packed {
		logic      valid;
		data_t     weight;
		logic      first;                   // Restarts the sum
		logic      last;                    // Bias term, closes the node
		layer_e    layer;
		node_idx_t node;
	} mac_term_t;

	typedef struct packed {
		logic      valid;
		layer_e    layer;
		node_idx_t node;
		data_t     data;
	} node_result_t;

endpackage

/* logic/layer_sequencer.sv */
module layer_sequencer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_inputs_ready,
	input  logic                 i_weight_valid,
	input  ff_pkg::data_t        i_weight,
	input  ff_pkg::node_result_t i_result,
	output ff_pkg::weight_req_t  o_weight_req,
	output ff_pkg::mac_term_t    o_term,
	output ff_pkg::layer_e       o_read_layer,
	output ff_pkg::node_idx_t    o_read_idx,
	output logic                 o_busy
);
	import ff_pkg::*;

	layer_e       state;
	layer_e       next_state;
	node_idx_t    n_in;                     // Input count, also the bias position
	node_idx_t    res_last;
	weight_addr_t req_last;
	logic         result_hit;
	logic         layer_done;
	logic         busy_q;

	weight_addr_t req_cnt;
	logic         req_done;

	logic         w_valid_q;
	data_t        w_data_q;
	node_idx_t    in_idx;
	node_idx_t    out_node;
	node_idx_t    res_cnt;

	logic         term_valid;
	data_t        term_weight;
	logic         term_first;
	logic         term_last;
	layer_e       term_layer;
	node_idx_t    term_node;
	node_idx_t    read_idx_q;

	// Shape of the layer being computed
	always_comb begin
		case (state)
			LAYER_HIDDEN_1: begin
				n_in       = node_idx_t'(N_INPUT);
				res_last   = node_idx_t'(N_HIDDEN_1 - 1);
				req_last   = weight_addr_t'(W_COUNT_H1 - 1);
				next_state = LAYER_HIDDEN_2;
			end
			LAYER_HIDDEN_2: begin
				n_in       = node_idx_t'(N_HIDDEN_1);
				res_last   = node_idx_t'(N_HIDDEN_2 - 1);
				req_last   = weight_addr_t'(W_COUNT_H2 - 1);
				next_state = LAYER_OUTPUT;
			end
			LAYER_OUTPUT: begin
				n_in       = node_idx_t'(N_HIDDEN_2);
				res_last   = node_idx_t'(N_OUTPUT - 1);
				req_last   = weight_addr_t'(W_COUNT_OUT - 1);
				next_state = LAYER_INPUT;
			end
			default: begin                      // Idle
				n_in       = node_idx_t'(N_INPUT);
				res_last   = '0;
				req_last   = '0;
				next_state = LAYER_HIDDEN_1;
			end
		endcase
	end

	assign result_hit = i_result.valid && (i_result.layer == state);
	assign layer_done = result_hit && (res_cnt == res_last);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= LAYER_INPUT;
			busy_q  <= 1'b0;
			res_cnt <= '0;
		end else begin
			busy_q <= (state != LAYER_INPUT);   // Lags the state by one cycle
			if ((state == LAYER_INPUT && i_inputs_ready) || layer_done)
				state <= next_state;
			if (layer_done)
				res_cnt <= '0;
			else if (result_hit)
				res_cnt <= res_cnt + 1'b1;
		end
	end

	// Requests go out back to back, one per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_weight_req <= '0;
			req_cnt      <= '0;
			req_done     <= 1'b0;
		end else begin
			o_weight_req.valid <= 1'b0;
			if (layer_done) begin
				req_cnt  <= '0;
				req_done <= 1'b0;
			end else if (state != LAYER_INPUT && !req_done) begin
				o_weight_req.valid <= 1'b1;
				o_weight_req.layer <= state;
				o_weight_req.addr  <= req_cnt;
				if (req_cnt == req_last)
					req_done <= 1'b1;
				else
					req_cnt <= req_cnt + 1'b1;
			end
		end
	end

	// Capture stage for returning weights
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			w_valid_q <= 1'b0;
		else
			w_valid_q <= i_weight_valid;
	end

	always_ff @(posedge clk) begin
		w_data_q <= i_weight;
	end

	// Term counters follow the weights, not the requests
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			term_valid <= 1'b0;
			in_idx     <= '0;
			out_node   <= '0;
		end else begin
			term_valid <= w_valid_q;
			if (layer_done) begin
				in_idx   <= '0;
				out_node <= '0;
			end else if (w_valid_q) begin
				if (in_idx == n_in) begin       // Bias word closes the node
					in_idx   <= '0;
					out_node <= out_node + 1'b1;
				end else begin
					in_idx <= in_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (w_valid_q) begin
			term_weight <= w_data_q;
			term_first  <= (in_idx == '0);
			term_last   <= (in_idx == n_in);
			term_layer  <= state;
			term_node   <= out_node;
			read_idx_q  <= in_idx;              // Aligns activation with the term
		end
	end

	assign o_term = '{
		valid:  term_valid,
		weight: term_weight,
		first:  term_first,
		last:   term_last,
		layer:  term_layer,
		node:   term_node
	};
	assign o_read_layer = state;
	assign o_read_idx   = read_idx_q;
	assign o_busy       = busy_q;

endmodule

/* logic/activation_store.sv */
module activation_store (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_data_valid,
	input  ff_pkg::node_idx_t    i_data_addr,
	input  ff_pkg::data_t        i_data,
	input  logic                 i_busy,
	input  ff_pkg::layer_e       i_read_layer,
	input  ff_pkg::node_idx_t    i_read_idx,
	input  ff_pkg::node_result_t i_result,
	output ff_pkg::data_t        o_activation,
	output logic                 o_inputs_ready
);
	import ff_pkg::*;

	data_t input_buf   [N_INPUT];
	data_t hidden1_buf [N_HIDDEN_1];
	data_t hidden2_buf [N_HIDDEN_2];
	logic  in_write;

	assign in_write = i_data_valid && !i_busy;   // Inputs locked during a run

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_INPUT; i++)
			if (in_write && i_data_addr == node_idx_t'(i))
				input_buf[i] <= i_data;
		for (int i = 0; i < N_HIDDEN_1; i++)
			if (i_result.valid && i_result.layer == LAYER_HIDDEN_1 && i_result.node == node_idx_t'(i))
				hidden1_buf[i] <= i_result.data;
		for (int i = 0; i < N_HIDDEN_2; i++)
			if (i_result.valid && i_result.layer == LAYER_HIDDEN_2 && i_result.node == node_idx_t'(i))
				hidden2_buf[i] <= i_result.data;
	end

	// Last input word starts the run
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_inputs_ready <= 1'b0;
		else
			o_inputs_ready <= in_write && (i_data_addr == node_idx_t'(N_INPUT - 1));
	end

	// Each layer reads the previous one, the slot past the end is the bias
	always_comb begin
		o_activation = '0;
		case (i_read_layer)
			LAYER_HIDDEN_1: begin
				o_activation = ONE_FIXED;
				for (int i = 0; i < N_INPUT; i++)
					if (i_read_idx == node_idx_t'(i))
						o_activation = input_buf[i];
			end
			LAYER_HIDDEN_2: begin
				o_activation = ONE_FIXED;
				for (int i = 0; i < N_HIDDEN_1; i++)
					if (i_read_idx == node_idx_t'(i))
						o_activation = hidden1_buf[i];
			end
			LAYER_OUTPUT: begin
				o_activation = ONE_FIXED;
				for (int i = 0; i < N_HIDDEN_2; i++)
					if (i_read_idx == node_idx_t'(i))
						o_activation = hidden2_buf[i];
			end
			default: o_activation = '0;          // Idle
		endcase
	end

endmodule

/* logic/neuron_mac.sv */
module neuron_mac (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ff_pkg::mac_term_t    i_term,
	input  ff_pkg::data_t        i_activation,
	output ff_pkg::node_result_t o_result
);
	import ff_pkg::*;

	acc_t      acc_q;
	acc_t      product;
	acc_t      sum;
	acc_t      scaled;
	data_t     clipped;
	data_t     activated;
	logic      close_node;

	logic      result_valid;
	layer_e    result_layer;
	node_idx_t result_node;
	data_t     result_data;

	assign product    = acc_t'(i_term.weight) * acc_t'(i_activation);
	assign sum        = i_term.first ? product : acc_q + product;
	assign scaled     = sum >>> FRAC_BITS;       // Floor, drops the fraction
	assign close_node = i_term.valid && i_term.last;

	// Clamp to the data range
	always_comb begin
		if (scaled > acc_t'(DATA_MAX))
			clipped = DATA_MAX;
		else if (scaled < acc_t'(DATA_MIN))
			clipped = DATA_MIN;
		else
			clipped = data_t'(scaled);
	end

	// Leaky rectifier, hidden layers only
	always_comb begin
		activated = clipped;
		if (i_term.layer != LAYER_OUTPUT && clipped[DATA_W-1])
			activated = clipped >>> LEAK_SHIFT;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= close_node;
	end

	always_ff @(posedge clk) begin
		if (i_term.valid)
			acc_q <= sum;
		if (close_node) begin
			result_layer <= i_term.layer;
			result_node  <= i_term.node;
			result_data  <= activated;
		end
	end

	assign o_result = '{
		valid: result_valid,
		layer: result_layer,
		node:  result_node,
		data:  result_data
	};

endmodule

/* logic/feed_forward.sv */
module feed_forward (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_data_valid,
	input  ff_pkg::node_idx_t    i_data_addr,
	input  ff_pkg::data_t        i_data,
	input  logic                 i_weight_valid,
	input  ff_pkg::data_t        i_weight,
	output logic                 o_weight_valid_request,
	output ff_pkg::layer_e       o_weight_layer_request,
	output ff_pkg::weight_addr_t o_weight_addr_request,
	output logic                 o_data_valid,
	output ff_pkg::layer_e       o_data_layer,
	output ff_pkg::node_idx_t    o_data_addr,
	output ff_pkg::data_t        o_data,
	output logic                 o_busy
);
	import ff_pkg::*;

	weight_req_t  weight_req;
	mac_term_t    term;
	layer_e       read_layer;
	node_idx_t    read_idx;
	data_t        activation;
	logic         inputs_ready;
	node_result_t result;
	logic         busy;

	layer_sequencer layer_sequencer_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_inputs_ready (inputs_ready),
		.i_weight_valid (i_weight_valid),
		.i_weight       (i_weight),
		.i_result       (result),
		.o_weight_req   (weight_req),
		.o_term         (term),
		.o_read_layer   (read_layer),
		.o_read_idx     (read_idx),
		.o_busy         (busy)
	);

	activation_store activation_store_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_data_valid   (i_data_valid),
		.i_data_addr    (i_data_addr),
		.i_data         (i_data),
		.i_busy         (busy),
		.i_read_layer   (read_layer),
		.i_read_idx     (read_idx),
		.i_result       (result),       // Hidden results written back
		.o_activation   (activation),
		.o_inputs_ready (inputs_ready)
	);

	neuron_mac neuron_mac_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_term       (term),
		.i_activation (activation),
		.o_result     (result)
	);

	assign o_weight_valid_request = weight_req.valid;
	assign o_weight_layer_request = weight_req.layer;
	assign o_weight_addr_request  = weight_req.addr;
	assign o_data_valid           = result.valid;
	assign o_data_layer           = result.layer;
	assign o_data_addr            = result.node;
	assign o_data                 = result.data;
	assign o_busy                 = busy;

endmodule

/* tests/feed_forward_tb.sv */
module feed_forward_tb;
	import ff_pkg::*;

	localparam int TIMEOUT_CYCLES = 3000;
	localparam int N_ROWS         = 6;
	localparam int N_RESULTS      = N_HIDDEN_1 + N_HIDDEN_2 + N_OUTPUT;

	typedef struct packed {
		data_t [N_INPUT-1:0] in_vec;
		logic                zero_delay;      // Weight memory answers at once
		logic [63:0]         label;
	} row_t;

	typedef struct packed {
		logic [31:0]  ready;                  // Cycle the word may be returned
		layer_e       layer;
		weight_addr_t addr;
	} pend_t;

	logic         clk = 1'b0;
	logic         rst_n;
	logic         i_data_valid;
	node_idx_t    i_data_addr;
	data_t        i_data;
	logic         i_weight_valid = 1'b0;
	data_t        i_weight = '0;
	logic         o_weight_valid_request;
	layer_e       o_weight_layer_request;
	weight_addr_t o_weight_addr_request;
	logic         o_data_valid;
	layer_e       o_data_layer;
	node_idx_t    o_data_addr;
	data_t        o_data;
	logic         o_busy;

	data_t        w_h1  [N_HIDDEN_1 * (N_INPUT + 1)];
	data_t        w_h2  [N_HIDDEN_2 * (N_HIDDEN_1 + 1)];
	data_t        w_out [N_OUTPUT * (N_HIDDEN_2 + 1)];
	row_t         rows  [N_ROWS];
	pend_t        pend_q [$];
	node_result_t res_q [$];
	layer_e       exp_layer [N_RESULTS];
	int           exp_node  [N_RESULTS];
	data_t        exp_data  [N_RESULTS];
	data_t        prev_data [N_RESULTS];
	logic [31:0]  rng = 32'hefb6;
	int           cycle = 0;
	int           last_req_cycle = 0;
	int           req_count [4];
	layer_e       req_layer = LAYER_HIDDEN_1;
	logic         armed = 1'b0;
	logic         zero_delay_mode = 1'b0;
	int           sat_seen = 0;
	int           neg_hidden_seen = 0;
	int           neg_out_seen = 0;

	feed_forward feed_forward_inst (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic data_t weight_at(input layer_e l, input int a);
		case (l)
			LAYER_HIDDEN_1: return w_h1[a];
			LAYER_HIDDEN_2: return w_h2[a];
			LAYER_OUTPUT:   return w_out[a];
			default:        return '0;
		endcase
	endfunction

	function automatic int layer_words(input int li);
		if (li == 1)
			return N_HIDDEN_1 * (N_INPUT + 1);
		if (li == 2)
			return N_HIDDEN_2 * (N_HIDDEN_1 + 1);
		return N_OUTPUT * (N_HIDDEN_2 + 1);
	endfunction

	task automatic abort_run(input string why);
		$display("%0t: %s", $time, why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic signed [31:0] exp_val,
		input logic signed [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp_val, act_val);
			$display("sim failed");
			$fatal(1, "mismatch");
		end
	endtask

	// Floor to the integer part, clamp, then leak for hidden layers
	function automatic data_t apply_neuron(input int sum, input logic hidden);
		int    scaled;
		data_t clipped;
		scaled = sum >>> FRAC_BITS;
		if (scaled > 32767)
			clipped = 16'sh7fff;
		else if (scaled < -32768)
			clipped = 16'sh8000;
		else
			clipped = data_t'(scaled);
		if (hidden && clipped < 0)
			return clipped >>> LEAK_SHIFT;
		return clipped;
	endfunction

	task automatic build_expected(input row_t row);
		data_t  src [32];
		data_t  dst [32];
		int     n_in;
		int     n_out;
		int     sum;
		int     pos;
		layer_e l;
		pos = 0;
		for (int i = 0; i < N_INPUT; i++)
			src[i] = row.in_vec[i];
		for (int li = 1; li <= 3; li++) begin
			l     = layer_e'(li);
			n_in  = (li == 1) ? N_INPUT : (li == 2) ? N_HIDDEN_1 : N_HIDDEN_2;
			n_out = (li == 1) ? N_HIDDEN_1 : (li == 2) ? N_HIDDEN_2 : N_OUTPUT;
			for (int n = 0; n < n_out; n++) begin
				sum = 0;
				for (int k = 0; k <= n_in; k++)
					sum += int'(weight_at(l, n * (n_in + 1) + k))
						* ((k == n_in) ? (1 << FRAC_BITS) : int'(src[k]));   // Bias pairs with 1.0
				if ((sum >>> FRAC_BITS) > 32767 || (sum >>> FRAC_BITS) < -32768)
					sat_seen++;
				dst[n] = apply_neuron(sum, li != 3);
				if (dst[n] < 0 && li == 3)
					neg_out_seen++;
				else if (dst[n] < 0)
					neg_hidden_seen++;
				exp_layer[pos] = l;
				exp_node[pos]  = n;
				exp_data[pos]  = dst[n];
				pos++;
			end
			for (int i = 0; i < n_out; i++)
				src[i] = dst[i];
		end
	endtask

	// Weight memory, request checker and result collector
	always @(negedge clk) begin
		if (o_weight_valid_request) begin
			if (!armed)
				abort_run("weight request seen before the last input was written");
			check_value("o_weight_layer_request", int'(req_layer), int'(o_weight_layer_request));
			check_value("o_weight_addr_request", req_count[req_layer],
				int'(o_weight_addr_request));
			if (req_count[req_layer] > 0)
				check_value("o_weight_valid_request cycle", last_req_cycle + 1, cycle);
			last_req_cycle = cycle;
			req_count[req_layer]++;
			if (req_count[req_layer] == layer_words(int'(req_layer)))
				req_layer = layer_e'(req_layer + 2'd1);   // Wraps to idle after the output layer
			rng = xorshift32(rng);
			pend_q.push_back(pend_t'{ready: cycle + (zero_delay_mode ? 0 : int'(rng[1:0])),
				layer: o_weight_layer_request, addr: o_weight_addr_request});
		end
		if (pend_q.size() > 0 && pend_q[0].ready <= cycle) begin
			i_weight_valid = 1'b1;
			i_weight       = weight_at(pend_q[0].layer, int'(pend_q[0].addr));
			void'(pend_q.pop_front());
		end else begin
			i_weight_valid = 1'b0;
			i_weight       = '0;
		end
		if (o_data_valid)
			res_q.push_back(node_result_t'{valid: 1'b1, layer: o_data_layer, node: o_data_addr,
				data: o_data});
		cycle++;
	end

	task automatic write_inputs(input row_t row);
		armed = 1'b0;
		for (int i = 0; i < N_INPUT; i++) begin
			i_data_valid = 1'b1;
			i_data_addr  = node_idx_t'(i);
			i_data       = row.in_vec[i];
			if (i == N_INPUT - 1)
				armed = 1'b1;
			@(negedge clk);
		end
		i_data_valid = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input string why);
		int waited;
		waited = 0;
		while (o_busy !== level) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES)
				abort_run(why);
		end
	endtask

	initial begin
		rows[0] = '{in_vec: {16'sh0040, 16'sh0180}, zero_delay: 1'b0, label: "pos_rand"};
		rows[1] = '{in_vec: {16'sh0040, 16'sh0180}, zero_delay: 1'b1, label: "pos_zero"};
		rows[2] = '{in_vec: {16'shff00, 16'shfe00}, zero_delay: 1'b0, label: "neg_rand"};
		rows[3] = '{in_vec: {16'sh7fff, 16'sh7fff}, zero_delay: 1'b0, label: "big_rand"};
		rows[4] = '{in_vec: {16'sh7000, 16'sh8000}, zero_delay: 1'b1, label: "big_zero"};
		rows[5] = '{in_vec: {16'shfccd, 16'sh0333}, zero_delay: 1'b0, label: "mix_rand"};
		// Weights within +-2.0
		foreach (w_h1[i]) begin
			rng     = xorshift32(rng);
			w_h1[i] = data_t'(int'(rng[9:0]) - 512);
		end
		foreach (w_h2[i]) begin
			rng     = xorshift32(rng);
			w_h2[i] = data_t'(int'(rng[9:0]) - 512);
		end
		foreach (w_out[i]) begin
			rng      = xorshift32(rng);
			w_out[i] = data_t'(int'(rng[9:0]) - 512);
		end
		rst_n        = 1'b0;
		i_data_valid = 1'b0;
		i_data_addr  = '0;
		i_data       = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check_value("o_weight_valid_request", 0, o_weight_valid_request);
		check_value("o_data_valid", 0, o_data_valid);
		check_value("o_busy", 0, o_busy);

		for (int r = 0; r < N_ROWS; r++) begin
			$display("%0t: row %0d %s", $time, r, rows[r].label);
			zero_delay_mode = rows[r].zero_delay;
			req_layer       = LAYER_HIDDEN_1;
			for (int l = 0; l < 4; l++)
				req_count[l] = 0;
			res_q.delete();
			build_expected(rows[r]);
			write_inputs(rows[r]);
			wait_busy(1'b1, "engine never became busy after the inputs were written");
			wait_busy(1'b0, "inference never finished");
			for (int li = 1; li <= 3; li++)
				check_value("weight request count", layer_words(li), req_count[li]);
			check_value("result count", N_RESULTS, res_q.size());
			for (int i = 0; i < N_RESULTS; i++) begin
				check_value("o_data_layer", int'(exp_layer[i]), int'(res_q[i].layer));
				check_value("o_data_addr", exp_node[i], int'(res_q[i].node));
				check_value("o_data", int'(exp_data[i]), int'(res_q[i].data));
				// Same inputs with another weight delay must give the same outputs
				if (r > 0 && rows[r].in_vec == rows[r-1].in_vec)
					check_value("o_data vs previous row", int'(prev_data[i]), int'(res_q[i].data));
				prev_data[i] = res_q[i].data;
			end
		end

		if (sat_seen == 0 || neg_hidden_seen == 0 || neg_out_seen == 0) begin
			abort_run("stimulus table missed saturation or negative results");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* vlog.f */
logic/ff_pkg.sv
logic/layer_sequencer.sv
logic/activation_store.sv
logic/neuron_mac.sv
logic/feed_forward.sv
tests/feed_forward_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the feed_forward testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module feed_forward_tb \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/Vfeed_forward_tb > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL: no result in log"; exit 1; }
